//--- hdl/fp_format_pkg.sv
// ============================================================
// Single-precision format: field widths, field types and
// special encodings
// ============================================================
`default_nettype none

package fp_format_pkg;

    // Field widths
    localparam int WORD_W = 32;
    localparam int EXP_W  = 8;
    localparam int MANT_W = 23;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [EXP_W-1:0]  exp_t;
    typedef logic [MANT_W-1:0] mant_t;

    // Exponent with room for carry and borrow during rounding
    typedef logic signed [EXP_W+1:0] exp_ext_t;

    // ============================================================
    // Special encodings
    // ============================================================
    localparam exp_t  EXP_MAX  = 8'd255;
    localparam exp_t  EXP_BIAS = 8'd127;

    // Canonical quiet NaN, positive sign
    localparam word_t QNAN = 32'h7FC0_0000;

    // Guard, round and sticky positions below the fraction
    localparam int GRS_BITS = 3;

endpackage

`default_nettype wire

//--- hdl/fp_alu_pkg.sv
// ============================================================
// ALU operation codes, flags, request/response structs and
// handshake controller states
// ============================================================
`default_nettype none

package fp_alu_pkg;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_I2F = 2'd3
    } alu_op_t;

    typedef struct packed {
        logic inexact;
        logic invalid;
        logic overflow;
        logic underflow;
    } fp_flags_t;

    // For OP_I2F, a holds the signed integer and b is ignored
    typedef struct packed {
        alu_op_t              op;
        fp_format_pkg::word_t a;
        fp_format_pkg::word_t b;
    } alu_req_t;

    typedef struct packed {
        fp_format_pkg::word_t result;
        fp_flags_t            flags;
    } alu_rsp_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CALC,
        S_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/fp_addsub.sv
// ============================================================
// Single-precision add/subtract, round to nearest even
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module fp_addsub (
    input  fp_format_pkg::word_t a,
    input  fp_format_pkg::word_t b,
    input  logic                 subtract,
    output fp_alu_pkg::alu_rsp_t rsp
);
    import fp_format_pkg::*;
    import fp_alu_pkg::*;

    logic  sign_a, sign_b;
    exp_t  exp_a, exp_b;
    mant_t mant_a, mant_b;
    logic  nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;

    logic  swap;
    logic  sign_big;
    exp_t  exp_big;
    exp_t  shift;
    logic  sticky;

    // {hidden, fraction, G, R, S}
    logic [MANT_W+GRS_BITS:0]   big_ext, small_ext, small_mask, aligned, norm;
    logic [MANT_W+GRS_BITS+1:0] sum;
    logic [4:0]                 lz;
    exp_ext_t                   exp_norm, exp_rnd;
    logic                       round_up;
    logic [MANT_W+1:0]          mant_rnd;
    mant_t                      frac;

    function automatic logic [4:0] lead_zeros(input logic [MANT_W+GRS_BITS:0] v);
        logic [4:0] n;
        logic       found;
        n = '0;
        found = 1'b0;
        for (int i = MANT_W + GRS_BITS; i >= 0; i--) begin
            if (!found && v[i]) begin
                n = 5'(MANT_W + GRS_BITS - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    assign {sign_a, exp_a, mant_a} = a;
    assign sign_b = b[WORD_W-1] ^ subtract;
    assign {exp_b, mant_b} = b[WORD_W-2:0];

    // Subnormals count as zero
    assign nan_a  = (exp_a == EXP_MAX) && (mant_a != '0);
    assign nan_b  = (exp_b == EXP_MAX) && (mant_b != '0);
    assign inf_a  = (exp_a == EXP_MAX) && (mant_a == '0);
    assign inf_b  = (exp_b == EXP_MAX) && (mant_b == '0);
    assign zero_a = (exp_a == '0);
    assign zero_b = (exp_b == '0);

    // ============================================================
    // Alignment of the smaller magnitude
    // ============================================================
    assign swap      = {exp_b, mant_b} > {exp_a, mant_a};
    assign sign_big  = swap ? sign_b : sign_a;
    assign exp_big   = swap ? exp_b : exp_a;
    assign shift     = swap ? (exp_b - exp_a) : (exp_a - exp_b);
    assign big_ext   = {1'b1, (swap ? mant_b : mant_a), {GRS_BITS{1'b0}}};
    assign small_ext = {1'b1, (swap ? mant_a : mant_b), {GRS_BITS{1'b0}}};

    // Bits shifted out collapse into the sticky position
    assign small_mask = ~({(MANT_W+GRS_BITS+1){1'b1}} << shift);
    assign sticky     = |(small_ext & small_mask);
    assign aligned    = (small_ext >> shift) | {{(MANT_W+GRS_BITS){1'b0}}, sticky};

    assign sum = (sign_a ^ sign_b) ? ({1'b0, big_ext} - {1'b0, aligned})
                                   : ({1'b0, big_ext} + {1'b0, aligned});

    // Normalize: carry out shifts right, cancellation shifts left
    always_comb begin
        lz = lead_zeros(sum[MANT_W+GRS_BITS:0]);
        if (sum[MANT_W+GRS_BITS+1]) begin
            norm     = {sum[MANT_W+GRS_BITS+1:2], sum[1] | sum[0]};
            exp_norm = $signed({2'b00, exp_big}) + 10'sd1;
        end else begin
            norm     = sum[MANT_W+GRS_BITS:0] << lz;
            exp_norm = $signed({2'b00, exp_big}) - $signed({5'b00000, lz});
        end
    end

    // Nearest even: guard set and (anything below or odd LSB)
    assign round_up = norm[GRS_BITS-1] & (|norm[GRS_BITS-2:0] | norm[GRS_BITS]);
    assign mant_rnd = {1'b0, norm[MANT_W+GRS_BITS:GRS_BITS]}
                    + {{(MANT_W+1){1'b0}}, round_up};
    assign exp_rnd  = exp_norm + $signed({9'b0, mant_rnd[MANT_W+1]});
    assign frac     = mant_rnd[MANT_W+1] ? mant_rnd[MANT_W:1] : mant_rnd[MANT_W-1:0];

    // ============================================================
    // Special cases and final packing
    // ============================================================
    always_comb begin
        rsp = '0;
        if (nan_a || nan_b) begin
            rsp.result = QNAN;
            rsp.flags.invalid = 1'b1;
        end else if (inf_a) begin
            if (inf_b && (sign_a != sign_b)) begin
                rsp.result = QNAN;
                rsp.flags.invalid = 1'b1;
            end else begin
                rsp.result = {sign_a, EXP_MAX, {MANT_W{1'b0}}};
            end
        end else if (inf_b) begin
            rsp.result = {sign_b, EXP_MAX, {MANT_W{1'b0}}};
        end else if (zero_a && zero_b) begin
            rsp.result = {sign_a & sign_b, {(WORD_W-1){1'b0}}};
        end else if (zero_a) begin
            rsp.result = {sign_b, exp_b, mant_b};
        end else if (zero_b) begin
            rsp.result = {sign_a, exp_a, mant_a};
        end else if (sum == '0) begin
            // Exact cancellation is +0
            rsp.result = '0;
        end else if (exp_rnd <= 10'sd0) begin
            rsp.result = {sign_big, {(WORD_W-1){1'b0}}};
            rsp.flags.underflow = 1'b1;
            rsp.flags.inexact   = 1'b1;
        end else if (exp_rnd >= $signed({2'b00, EXP_MAX})) begin
            rsp.result = {sign_big, EXP_MAX, {MANT_W{1'b0}}};
            rsp.flags.overflow = 1'b1;
            rsp.flags.inexact  = 1'b1;
        end else begin
            rsp.result = {sign_big, exp_rnd[EXP_W-1:0], frac};
            rsp.flags.inexact = |norm[GRS_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/fp_mul.sv
// ============================================================
// Single-precision multiply, round to nearest even
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module fp_mul (
    input  fp_format_pkg::word_t a,
    input  fp_format_pkg::word_t b,
    output fp_alu_pkg::alu_rsp_t rsp
);
    import fp_format_pkg::*;
    import fp_alu_pkg::*;

    logic  sign_a, sign_b, sign_r;
    exp_t  exp_a, exp_b;
    mant_t mant_a, mant_b;
    logic  nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;

    logic [2*MANT_W+1:0] prod, prod_n;
    exp_ext_t            exp_sum, exp_rnd;
    logic                guard, sticky, round_up;
    logic [MANT_W+1:0]   mant_rnd;
    mant_t               frac;

    assign {sign_a, exp_a, mant_a} = a;
    assign {sign_b, exp_b, mant_b} = b;
    assign sign_r = sign_a ^ sign_b;

    assign nan_a  = (exp_a == EXP_MAX) && (mant_a != '0);
    assign nan_b  = (exp_b == EXP_MAX) && (mant_b != '0);
    assign inf_a  = (exp_a == EXP_MAX) && (mant_a == '0);
    assign inf_b  = (exp_b == EXP_MAX) && (mant_b == '0);
    assign zero_a = (exp_a == '0);
    assign zero_b = (exp_b == '0);

    assign prod = {1'b1, mant_a} * {1'b1, mant_b};

    // Product of two [1,2) values lies in [1,4), at most one place to fix
    assign prod_n  = prod[2*MANT_W+1] ? prod : (prod << 1);
    assign exp_sum = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                   - $signed({2'b00, EXP_BIAS})
                   + $signed({9'b0, prod[2*MANT_W+1]});

    assign guard    = prod_n[MANT_W];
    assign sticky   = |prod_n[MANT_W-1:0];
    assign round_up = guard & (sticky | prod_n[MANT_W+1]);
    assign mant_rnd = {1'b0, prod_n[2*MANT_W+1:MANT_W+1]}
                    + {{(MANT_W+1){1'b0}}, round_up};
    assign exp_rnd  = exp_sum + $signed({9'b0, mant_rnd[MANT_W+1]});
    assign frac     = mant_rnd[MANT_W+1] ? mant_rnd[MANT_W:1] : mant_rnd[MANT_W-1:0];

    always_comb begin
        rsp = '0;
        if (nan_a || nan_b) begin
            rsp.result = QNAN;
            rsp.flags.invalid = 1'b1;
        end else if ((zero_a && inf_b) || (inf_a && zero_b)) begin
            rsp.result = QNAN;
            rsp.flags.invalid = 1'b1;
        end else if (inf_a || inf_b) begin
            rsp.result = {sign_r, EXP_MAX, {MANT_W{1'b0}}};
        end else if (zero_a || zero_b) begin
            rsp.result = {sign_r, {(WORD_W-1){1'b0}}};
        end else if (exp_rnd <= 10'sd0) begin
            rsp.result = {sign_r, {(WORD_W-1){1'b0}}};
            rsp.flags.underflow = 1'b1;
            rsp.flags.inexact   = 1'b1;
        end else if (exp_rnd >= $signed({2'b00, EXP_MAX})) begin
            rsp.result = {sign_r, EXP_MAX, {MANT_W{1'b0}}};
            rsp.flags.overflow = 1'b1;
            rsp.flags.inexact  = 1'b1;
        end else begin
            rsp.result = {sign_r, exp_rnd[EXP_W-1:0], frac};
            rsp.flags.inexact = guard | sticky;
        end
    end

endmodule

`default_nettype wire

//--- hdl/int_to_float.sv
// ============================================================
// Signed 32-bit integer to single-precision conversion
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module int_to_float (
    input  fp_format_pkg::word_t a_int,
    output fp_format_pkg::word_t result,
    output logic                 inexact
);
    import fp_format_pkg::*;

    logic              sign;
    word_t             mag, norm;
    logic [4:0]        lz;
    logic              round_up;
    logic [MANT_W+1:0] mant_rnd;
    exp_t              exp_r;
    mant_t             frac;

    function automatic logic [4:0] lead_zeros(input word_t v);
        logic [4:0] n;
        logic       found;
        n = '0;
        found = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (!found && v[i]) begin
                n = 5'(WORD_W - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    // Two's complement magnitude, 80000000 maps onto itself
    assign sign = a_int[WORD_W-1];
    assign mag  = sign ? (~a_int + 32'd1) : a_int;
    assign lz   = lead_zeros(mag);
    assign norm = mag << lz;

    // Top 24 bits kept, lower 8 feed guard and sticky
    assign round_up = norm[7] & (|norm[6:0] | norm[8]);
    assign mant_rnd = {1'b0, norm[WORD_W-1:8]} + {{(MANT_W+1){1'b0}}, round_up};
    assign exp_r    = EXP_BIAS + exp_t'(WORD_W - 1) - exp_t'(lz)
                    + exp_t'(mant_rnd[MANT_W+1]);
    assign frac     = mant_rnd[MANT_W+1] ? mant_rnd[MANT_W:1] : mant_rnd[MANT_W-1:0];

    assign result  = (a_int == '0) ? '0 : {sign, exp_r, frac};
    assign inexact = |norm[7:0];

endmodule

`default_nettype wire

//--- hdl/fp_alu_top.sv
// ============================================================
// FPU top level: req/ack controller, unit select and
// registered response
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module fp_alu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  fp_alu_pkg::alu_req_t cmd,
    output logic                 ack,
    output fp_alu_pkg::alu_rsp_t rsp
);
    import fp_format_pkg::*;
    import fp_alu_pkg::*;

    ctrl_state_t state;
    alu_req_t    cmd_q;
    alu_rsp_t    addsub_rsp, mul_rsp, sel_rsp;
    word_t       i2f_result;
    logic        i2f_inexact;

    // ============================================================
    // Arithmetic units, all combinational on the captured request
    // ============================================================
    fp_addsub u_addsub (
        .a        (cmd_q.a),
        .b        (cmd_q.b),
        .subtract (cmd_q.op == OP_SUB),
        .rsp      (addsub_rsp)
    );

    fp_mul u_mul (
        .a   (cmd_q.a),
        .b   (cmd_q.b),
        .rsp (mul_rsp)
    );

    int_to_float u_i2f (
        .a_int   (cmd_q.a),
        .result  (i2f_result),
        .inexact (i2f_inexact)
    );

    always_comb begin
        sel_rsp = '0;
        case (cmd_q.op)
            OP_ADD, OP_SUB: sel_rsp = addsub_rsp;
            OP_MUL:         sel_rsp = mul_rsp;
            OP_I2F: begin
                // Conversion can only be inexact
                sel_rsp.result        = i2f_result;
                sel_rsp.flags.inexact = i2f_inexact;
            end
            default: sel_rsp = '0;
        endcase
    end

    // Request capture, one operation per handshake
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req) begin
            cmd_q <= cmd;
        end
    end

    // ============================================================
    // Handshake controller
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            ack   <= 1'b0;
            rsp   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= S_CALC;
                    end
                end
                S_CALC: begin
                    rsp   <= sel_rsp;
                    state <= S_DONE;
                end
                S_DONE: begin
                    // Raise ack once, then wait for req to drop
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sim/fp_alu_chk.sv
// ============================================================
// Handshake assertions for the FPU top level
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module fp_alu_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 req,
    input logic                 ack,
    input fp_alu_pkg::alu_rsp_t rsp
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose without req");

    rsp_stable: assert property (@(posedge clk) disable iff (rst)
        ack |-> $stable(rsp))
        else $error("rsp changed while ack was high");

    // One edge to see req low, ack is low by the next
    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        $fell(req) |=> !ack)
        else $error("ack stayed high after req fell");

endmodule

bind fp_alu_top fp_alu_chk chk (.clk(clk), .rst(rst), .req(req), .ack(ack), .rsp(rsp));

`default_nettype wire

//--- sim/fp_alu_tb.sv
// ============================================================
// FPU testbench that reads the test vectors, runs req/ack
// handshakes with random gaps and holds and checks responses
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module fp_alu_tb;
    import fp_format_pkg::*;
    import fp_alu_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int MAX_TESTS      = 64;
    localparam int WORDS_PER_TEST = 5;

    logic     clk;
    logic     rst;
    logic     req;
    alu_req_t cmd;
    logic     ack;
    alu_rsp_t rsp;

    // Five words per test as op, a, b, result and flags
    word_t test_mem [0:MAX_TESTS*WORDS_PER_TEST-1];
    int    num_tests;
    int    cycle_count;
    int    cycle_limit;
    int    acks_seen;
    logic  ack_prev;

    fp_alu_top dut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .cmd (cmd),
        .ack (ack),
        .rsp (rsp)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: %s is %08h, expected %08h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic load_tests();
        for (int i = 0; i < MAX_TESTS * WORDS_PER_TEST; i++) begin
            // Marker above any op code that differs per address
            test_mem[i] = 32'hF000_0000 | i;
        end
        $readmemh("sim/fp_alu_tests.txt", test_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && test_mem[num_tests * WORDS_PER_TEST] <= 32'd3) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            abort_run("no tests found in sim/fp_alu_tests.txt");
        end
    endtask

    task automatic run_test(input int idx);
        word_t    exp_result;
        word_t    exp_flags;
        int       gap;
        int       hold;
        int       base;
        base       = idx * WORDS_PER_TEST;
        exp_result = test_mem[base + 3];
        exp_flags  = test_mem[base + 4];
        gap        = $urandom % 6;
        hold       = $urandom % 7;

        repeat (gap) @(negedge clk);
        cmd.op = alu_op_t'(test_mem[base][1:0]);
        cmd.a  = test_mem[base + 1];
        cmd.b  = test_mem[base + 2];
        req    = 1'b1;

        @(negedge clk);
        while (!ack) @(negedge clk);
        check_value(rsp.result, exp_result, $sformatf("test %0d result", idx));
        check_value(word_t'(rsp.flags), exp_flags, $sformatf("test %0d flags", idx));

        // Back-pressure with req held high
        repeat (hold) begin
            @(negedge clk);
            check_value(word_t'(ack), 32'd1, $sformatf("test %0d ack during hold", idx));
            check_value(rsp.result, exp_result,
                        $sformatf("test %0d result during hold", idx));
            check_value(word_t'(rsp.flags), exp_flags,
                        $sformatf("test %0d flags during hold", idx));
        end
        req = 1'b0;

        // ack drops on the first edge that sees req low
        @(negedge clk);
        check_value(word_t'(ack), 32'd0, $sformatf("test %0d ack after req low", idx));
    endtask

    // One count per rising ack
    always @(negedge clk) begin
        if (!rst && ack && !ack_prev) begin
            acks_seen++;
        end
        ack_prev = ack;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        void'($urandom(30698));
        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        cmd         = '0;
        cycle_count = 0;
        cycle_limit = 0;
        acks_seen   = 0;
        ack_prev    = 1'b0;
        load_tests();
        // Reset plus 20 cycles for each test
        cycle_limit = RESET_CYCLES + 2 + num_tests * 20;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value(word_t'(ack), 32'd0, "ack after reset");
        check_value(rsp.result, 32'd0, "result after reset");
        check_value(word_t'(rsp.flags), 32'd0, "flags after reset");

        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end

        @(negedge clk);
        check_value(word_t'(acks_seen), word_t'(num_tests), "number of acks");

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/fp_alu_tests.txt
// Columns: op (0 add, 1 sub, 2 mul, 3 int to float), a, b, result, flags
// Flags are {inexact, invalid, overflow, underflow}; all hex, b unused for op 3
0 3F800000 40000000 40400000 0
0 3F800000 33C00000 3F800001 8
0 3F800000 33800000 3F800000 8
0 3F800001 33800000 3F800002 8
1 3F800000 33800000 3F7FFFFF 0
0 BFC00000 3FC00000 00000000 0
0 7F7FFFFF 7F7FFFFF 7F800000 A
1 7F800000 7F800000 7FC00000 4
0 7F800001 3F800000 7FC00000 4
2 3FC00000 40000000 40400000 0
2 3F800001 3F800001 3F800002 8
2 00000000 7F800000 7FC00000 4
2 FF000000 40800000 FF800000 A
2 80800000 3F000000 80000000 9
2 00400000 C0000000 80000000 0
3 00000000 00000000 00000000 0
3 00000064 00000000 42C80000 0
3 FFFFFFF9 00000000 C0E00000 0
3 80000000 00000000 CF000000 0
3 7FFFFFFF 00000000 4F000000 8
3 01000001 00000000 4B800000 8

//--- src.f
hdl/fp_format_pkg.sv
hdl/fp_alu_pkg.sv
hdl/fp_addsub.sv
hdl/fp_mul.sv
hdl/int_to_float.sv
hdl/fp_alu_top.sv
sim/fp_alu_chk.sv
sim/fp_alu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fp_alu_tb -f src.f -o fp_alu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/fp_alu_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
